// File: Bender.yml
package:
  name: wb8_periph

export_include_dirs:
  - design

sources:
  - files:
      - design/wb8_pkg.sv
      - design/wb8_ram.sv
      - design/wb8_leds.sv
      - design/wb8_timer.sv
      - design/wb8_bus_decoder.sv
      - design/wb8_periph_top.sv
  - target: simulation
    files:
      - tests/wb8_periph_tb.sv

// File: compile.f
+incdir+design
design/wb8_pkg.sv
design/wb8_ram.sv
design/wb8_leds.sv
design/wb8_timer.sv
design/wb8_bus_decoder.sv
design/wb8_periph_top.sv
tests/wb8_periph_tb.sv

// File: design/wb8_bus_decoder.sv
`timescale 1ns/1ps

`include "wb8_macros.svh"

module wb8_bus_decoder (
    input  wb8_pkg::wb8_req_t req_i,
    output wb8_pkg::wb8_req_t ram_req_o,
    output wb8_pkg::wb8_req_t leds_req_o,
    output wb8_pkg::wb8_req_t timer_req_o,
    input  wb8_pkg::wb8_rsp_t ram_rsp_i,
    input  wb8_pkg::wb8_rsp_t leds_rsp_i,
    input  wb8_pkg::wb8_rsp_t timer_rsp_i,
    output wb8_pkg::wb8_rsp_t rsp_o
);

    wb8_pkg::wb8_dev_e dev;

    // address map
    always_comb begin
        if (req_i.adr[31:28] == `WB8_IO_NIBBLE) begin
            if (req_i.adr[27:24] == `WB8_TIMER_SEL) begin
                dev = wb8_pkg::DEV_TIMER;
            end else begin
                dev = wb8_pkg::DEV_LEDS; // rest of I/O space
            end
        end else begin
            dev = wb8_pkg::DEV_RAM;
        end
    end

    // shared adr/we/dat, private stb
    always_comb begin
        ram_req_o       = req_i;
        leds_req_o      = req_i;
        timer_req_o     = req_i;
        ram_req_o.stb   = req_i.stb && (dev == wb8_pkg::DEV_RAM);
        leds_req_o.stb  = req_i.stb && (dev == wb8_pkg::DEV_LEDS);
        timer_req_o.stb = req_i.stb && (dev == wb8_pkg::DEV_TIMER);
    end

    // reply from the selected slave only
    always_comb begin
        case (dev)
            wb8_pkg::DEV_LEDS:  rsp_o = leds_rsp_i;
            wb8_pkg::DEV_TIMER: rsp_o = timer_rsp_i;
            default:            rsp_o = ram_rsp_i;
        endcase
    end

    always_comb begin
        assert ($onehot0({ram_req_o.stb, leds_req_o.stb, timer_req_o.stb}))
        else $error("wb8_bus_decoder: more than one slave strobed");
    end

endmodule

// File: design/wb8_leds.sv
`timescale 1ns/1ps

module wb8_leds (
    input  logic              clk,
    input  logic              rst_i,
    input  wb8_pkg::wb8_req_t req_i,
    output wb8_pkg::wb8_rsp_t rsp_o,
    output logic [7:0]        leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       start;

    assign start = req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00; // all off out of reset
        end else begin
            ack_q <= start;
            if (start && req_i.we) begin
                leds_q <= req_i.dat; // lands with ack
            end
        end
    end

    assign leds_o = leds_q;
    // readback straight from the register
    assign rsp_o  = wb8_pkg::wb8_rsp_t'{dat: leds_q, ack: ack_q};

    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (rst_i)
        $rose(ack_q) |-> $past(req_i.stb)
    ) else $error("wb8_leds: ack without a preceding stb");

endmodule

// File: design/wb8_macros.svh
`ifndef WB8_MACROS_SVH
`define WB8_MACROS_SVH

// memory map
// top address nibble of the I/O window
`define WB8_IO_NIBBLE 4'hF

// second nibble inside I/O that picks the timer
`define WB8_TIMER_SEL 4'h5

// RAM size as address bits, 10 gives 1 KiB
`define WB8_RAM_ADDR_BITS 10

`endif

// File: design/wb8_periph_top.sv
`timescale 1ns/1ps

module wb8_periph_top (
    input  logic              clk,
    input  logic              rst_i,
    input  wb8_pkg::wb8_req_t req_i,
    output wb8_pkg::wb8_rsp_t rsp_o,
    output logic [7:0]        leds_o,
    output logic              irq_o
);

    // per-slave request and reply
    wb8_pkg::wb8_req_t ram_req;
    wb8_pkg::wb8_req_t leds_req;
    wb8_pkg::wb8_req_t timer_req;
    wb8_pkg::wb8_rsp_t ram_rsp;
    wb8_pkg::wb8_rsp_t leds_rsp;
    wb8_pkg::wb8_rsp_t timer_rsp;

    wb8_bus_decoder wb8_bus_decoder_inst (
        .req_i       (req_i),
        .ram_req_o   (ram_req),
        .leds_req_o  (leds_req),
        .timer_req_o (timer_req),
        .ram_rsp_i   (ram_rsp),
        .leds_rsp_i  (leds_rsp),
        .timer_rsp_i (timer_rsp),
        .rsp_o       (rsp_o)
    );

    // 1 KiB by default
    wb8_ram wb8_ram_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    wb8_leds wb8_leds_inst (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (leds_req),
        .rsp_o  (leds_rsp),
        .leds_o (leds_o)
    );

    wb8_timer wb8_timer_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (timer_req),
        .rsp_o (timer_rsp),
        .irq_o (irq_o)
    );

endmodule

// File: design/wb8_pkg.sv
package wb8_pkg;

    // master request, one classic-cycle transfer
    typedef struct packed {
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [7:0]  dat; // write data
    } wb8_req_t;

    // slave reply
    typedef struct packed {
        logic [7:0] dat; // read data, valid with ack
        logic       ack;
    } wb8_rsp_t;

    // which slave the decoder picked
    typedef enum logic [1:0] {
        DEV_RAM,
        DEV_LEDS,
        DEV_TIMER
    } wb8_dev_e;

    // timer register offsets, adr[1:0]
    typedef enum logic [1:0] {
        TMR_CTRL   = 2'd0, // bit 0 enable
        TMR_CMP    = 2'd1,
        TMR_COUNT  = 2'd2, // read and load
        TMR_STATUS = 2'd3  // bit 0 match flag, write 1 to clear
    } timer_reg_e;

endpackage

// File: design/wb8_ram.sv
`timescale 1ns/1ps

`include "wb8_macros.svh"

module wb8_ram #(
    parameter int ADDR_BITS = `WB8_RAM_ADDR_BITS
) (
    input  logic              clk,
    input  logic              rst_i,
    input  wb8_pkg::wb8_req_t req_i,
    output wb8_pkg::wb8_rsp_t rsp_o
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [7:0]           mem [0:DEPTH-1];
    logic [7:0]           dat_q;
    logic                 ack_q;
    logic                 start;
    logic [ADDR_BITS-1:0] addr;

    if (ADDR_BITS < 4 || ADDR_BITS > 14) begin : g_bad_size
        $error("wb8_ram: ADDR_BITS must be between 4 and 14");
    end

    assign start = req_i.stb && !ack_q; // first cycle of a transfer
    assign addr  = req_i.adr[ADDR_BITS-1:0]; // upper bits alias

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start; // one-cycle pulse
        end
    end

    // storage and read port
    always_ff @(posedge clk) begin
        if (start && req_i.we) begin
            mem[addr] <= req_i.dat;
        end
        if (start) begin
            dat_q <= mem[addr];
        end
    end

    assign rsp_o = wb8_pkg::wb8_rsp_t'{dat: dat_q, ack: ack_q};

    // an ack pulse must answer a strobe seen on the edge before
    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (rst_i)
        $rose(ack_q) |-> $past(req_i.stb)
    ) else $error("wb8_ram: ack without a preceding stb");

endmodule

// File: design/wb8_timer.sv
`timescale 1ns/1ps

module wb8_timer (
    input  logic              clk,
    input  logic              rst_i,
    input  wb8_pkg::wb8_req_t req_i,
    output wb8_pkg::wb8_rsp_t rsp_o,
    output logic              irq_o
);

    wb8_pkg::timer_reg_e reg_sel;

    logic       en_q;
    logic [7:0] cmp_q;
    logic [7:0] cnt_q;
    logic       flag_q;  // sticky match
    logic       ack_q;
    logic [7:0] dat_q;
    logic       start;
    logic       wr_en;
    logic       match;

    assign reg_sel = wb8_pkg::timer_reg_e'(req_i.adr[1:0]);
    assign start   = req_i.stb && !ack_q;
    assign wr_en   = start && req_i.we;
    assign match   = (cnt_q == cmp_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            en_q   <= 1'b0;
            cmp_q  <= 8'h00;
            cnt_q  <= 8'h00;
            flag_q <= 1'b0;
        end else begin
            ack_q <= start;

            if (wr_en && reg_sel == wb8_pkg::TMR_CTRL) begin
                en_q <= req_i.dat[0];
            end
            if (wr_en && reg_sel == wb8_pkg::TMR_CMP) begin
                cmp_q <= req_i.dat;
            end

            // bus load beats counting
            if (wr_en && reg_sel == wb8_pkg::TMR_COUNT) begin
                cnt_q <= req_i.dat;
            end else if (en_q) begin
                cnt_q <= match ? 8'h00 : cnt_q + 8'h01; // wrap on compare
            end

            if (en_q && match) begin
                flag_q <= 1'b1;
            end else if (wr_en && reg_sel == wb8_pkg::TMR_STATUS && req_i.dat[0]) begin
                flag_q <= 1'b0; // write-one-to-clear
            end
        end
    end

    // read mux, sampled on the first strobe cycle
    always_ff @(posedge clk) begin
        if (start) begin
            case (reg_sel)
                wb8_pkg::TMR_CTRL:   dat_q <= {7'b0, en_q};
                wb8_pkg::TMR_CMP:    dat_q <= cmp_q;
                wb8_pkg::TMR_COUNT:  dat_q <= cnt_q;
                wb8_pkg::TMR_STATUS: dat_q <= {7'b0, flag_q};
                default:             dat_q <= 8'h00;
            endcase
        end
    end

    assign irq_o = flag_q;
    assign rsp_o = wb8_pkg::wb8_rsp_t'{dat: dat_q, ack: ack_q};

    // interrupt only rises after the running counter hit compare
    a_irq_on_match: assert property (
        @(posedge clk) disable iff (rst_i)
        $rose(irq_o) |-> $past(en_q && cnt_q == cmp_q)
    ) else $error("wb8_timer: irq_o rose without a compare match");

endmodule

// File: tests/wb8_periph_tb.sv
`timescale 1ns/1ps

`include "wb8_macros.svh"

module wb8_periph_tb;

    localparam int MAX_ENTRIES = 48;
    localparam int FLAG_WINDOW = 200; // cycles allowed for the timer match
    localparam logic [31:0] TIMER_BASE = {`WB8_IO_NIBBLE, `WB8_TIMER_SEL, 24'h0};

    logic              clk;
    logic              rst_i;
    wb8_pkg::wb8_req_t req;
    wb8_pkg::wb8_rsp_t rsp;
    logic [7:0]        leds_o;
    logic              irq_o;

    // stimulus table, one bus transfer per row
    string       t_name    [MAX_ENTRIES];
    logic        t_we      [MAX_ENTRIES];
    logic [31:0] t_adr     [MAX_ENTRIES];
    logic [7:0]  t_wdat    [MAX_ENTRIES];
    logic [7:0]  t_exp     [MAX_ENTRIES];
    logic        t_chk_led [MAX_ENTRIES];
    logic        t_poll    [MAX_ENTRIES]; // read until status bit 0 is set
    logic        t_chk_irq [MAX_ENTRIES];
    logic        t_irq_exp [MAX_ENTRIES];
    int          n_entries;
    logic        table_ready;

    integer      seed;
    logic [7:0]  ram_dat [6]; // random RAM bytes
    int          cycle_cnt;

    wb8_periph_top wb8_periph_top_inst (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (req),
        .rsp_o  (rsp),
        .leds_o (leds_o),
        .irq_o  (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp)
        else fail_run($sformatf("Mismatch in %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic add_entry(input string name, input logic we, input logic [31:0] adr,
                             input logic [7:0] wdat, input logic [7:0] exp,
                             input logic chk_led, input logic poll,
                             input logic chk_irq, input logic irq_exp);
        t_name[n_entries]    = name;
        t_we[n_entries]      = we;
        t_adr[n_entries]     = adr;
        t_wdat[n_entries]    = wdat;
        t_exp[n_entries]     = exp;
        t_chk_led[n_entries] = chk_led;
        t_poll[n_entries]    = poll;
        t_chk_irq[n_entries] = chk_irq;
        t_irq_exp[n_entries] = irq_exp;
        n_entries = n_entries + 1;
    endtask

    task automatic add_write(input string name, input logic [31:0] adr, input logic [7:0] dat,
                             input logic chk_led);
        add_entry(name, 1'b1, adr, dat, 8'h00, chk_led, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic add_read(input string name, input logic [31:0] adr, input logic [7:0] exp);
        add_entry(name, 1'b0, adr, 8'h00, exp, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        n_entries = 0;
        seed = 32'h10909054;
        for (int i = 0; i < 6; i++) begin
            ram_dat[i] = 8'($random(seed));
        end
        add_write("ram wr 0x000", 32'h0000_0000, ram_dat[0], 1'b0);
        add_write("ram wr 0x001", 32'h0000_0001, ram_dat[1], 1'b0);
        add_write("ram wr 0x055", 32'h0000_0055, ram_dat[2], 1'b0);
        add_write("ram wr 0x200", 32'h0000_0200, ram_dat[3], 1'b0);
        add_write("ram wr 0x3ff", 32'h0000_03FF, ram_dat[4], 1'b0);
        add_read("ram rd 0x000", 32'h0000_0000, ram_dat[0]);
        add_read("ram rd 0x001", 32'h0000_0001, ram_dat[1]);
        add_read("ram rd 0x055", 32'h0000_0055, ram_dat[2]);
        add_read("ram rd 0x200", 32'h0000_0200, ram_dat[3]);
        add_read("ram rd 0x3ff", 32'h0000_03FF, ram_dat[4]);
        // only 10 address bits kept, 0x400 lands on 0
        add_read("ram alias rd 0x400", 32'h0000_0400, ram_dat[0]);
        add_write("ram alias wr 0x400", 32'h0000_0400, ram_dat[5], 1'b0);
        add_read("ram alias rd 0x000", 32'h0000_0000, ram_dat[5]);
        add_write("leds wr 0xf0000000", 32'hF000_0000, 8'hA5, 1'b1);
        add_read("leds rd 0xf0000000", 32'hF000_0000, 8'hA5);
        add_write("leds wr 0xf2345678", 32'hF234_5678, 8'h3C, 1'b1);
        add_read("leds rd 0xf2abcdef", 32'hF2AB_CDEF, 8'h3C);
        add_read("ram kept 0x000", 32'h0000_0000, ram_dat[5]); // untouched by LED writes
        add_read("ram kept 0x055", 32'h0000_0055, ram_dat[2]);
        add_read("ram kept 0x3ff", 32'h0000_03FF, ram_dat[4]);
        add_write("timer wr count", TIMER_BASE | 32'(wb8_pkg::TMR_COUNT), 8'h5A, 1'b0);
        add_read("timer rd count", TIMER_BASE | 32'(wb8_pkg::TMR_COUNT), 8'h5A);
        add_read("timer rd ctrl", TIMER_BASE | 32'(wb8_pkg::TMR_CTRL), 8'h00);
        add_write("timer wr cmp", TIMER_BASE | 32'(wb8_pkg::TMR_CMP), 8'd20, 1'b0);
        add_write("timer clr count", TIMER_BASE | 32'(wb8_pkg::TMR_COUNT), 8'h00, 1'b0);
        add_read("timer rd cmp", TIMER_BASE | 32'(wb8_pkg::TMR_CMP), 8'd20);
        add_write("timer enable", TIMER_BASE | 32'(wb8_pkg::TMR_CTRL), 8'h01, 1'b0);
        add_entry("timer poll match", 1'b0, TIMER_BASE | 32'(wb8_pkg::TMR_STATUS),
                  8'h00, 8'h01, 1'b0, 1'b1, 1'b1, 1'b1);
        add_write("timer disable", TIMER_BASE | 32'(wb8_pkg::TMR_CTRL), 8'h00, 1'b0);
        add_write("timer clr flag", TIMER_BASE | 32'(wb8_pkg::TMR_STATUS), 8'h01, 1'b0);
        add_entry("timer rd status", 1'b0, TIMER_BASE | 32'(wb8_pkg::TMR_STATUS),
                  8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0);
        table_ready = 1'b1;
    endtask

    // one classic cycle, entered and left on a falling edge
    task automatic bus_transfer(input string name, input logic we, input logic [31:0] adr,
                                input logic [7:0] wdat, output logic [7:0] rdat);
        int cycles;
        cycles = 0;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
        end while (rsp.ack !== 1'b1 && cycles < 8);
        assert (rsp.ack === 1'b1)
        else fail_run($sformatf("%s: no ack after %0d cycles of stb", name, cycles));
        assert (cycles == 1)
        else fail_run($sformatf("Mismatch in %s ack latency: expected 1, actual %0d",
                                name, cycles));
        rdat = rsp.dat;
        req.stb = 1'b0; // idle cycle follows
        req.we  = 1'b0;
        @(negedge clk);
        assert (rsp.ack === 1'b0)
        else fail_run($sformatf("%s: ack stayed high for more than one cycle", name));
    endtask

    task automatic poll_flag(input string name, input logic [31:0] adr,
                             output logic [7:0] status);
        int start_cycle;
        start_cycle = cycle_cnt;
        status = 8'h00;
        while (status[0] !== 1'b1) begin
            assert (cycle_cnt - start_cycle <= FLAG_WINDOW)
            else fail_run($sformatf("%s: match flag not set within %0d cycles",
                                    name, FLAG_WINDOW));
            bus_transfer(name, 1'b0, adr, 8'h00, status);
        end
    endtask

    initial begin
        logic [7:0] rdat;
        rst_i       = 1'b1;
        req         = '0;
        table_ready = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        check_byte("reset leds_o", 8'h00, leds_o);
        assert (irq_o === 1'b0) else fail_run("irq_o is not low after reset");
        assert (rsp.ack === 1'b0) else fail_run("ack is not low after reset");

        for (int i = 0; i < n_entries; i++) begin
            if (t_poll[i]) begin
                poll_flag(t_name[i], t_adr[i], rdat);
            end else begin
                bus_transfer(t_name[i], t_we[i], t_adr[i], t_wdat[i], rdat);
            end
            if (!t_we[i]) begin
                check_byte(t_name[i], t_exp[i], rdat);
            end
            if (t_chk_led[i]) begin
                check_byte($sformatf("%s leds_o", t_name[i]), t_wdat[i], leds_o);
            end
            if (t_chk_irq[i]) begin
                assert (irq_o === t_irq_exp[i])
                else fail_run($sformatf("Mismatch in %s irq_o: expected %b, actual %b",
                                        t_name[i], t_irq_exp[i], irq_o));
            end
        end

        $display("TEST OK");
        $finish;
    end

    // watchdog scaled to the table length
    initial begin
        wait (table_ready);
        repeat (n_entries * 10 + 600) @(posedge clk);
        fail_run("timeout: the test did not finish in time");
    end

endmodule
